//--- design/crossbar.sv
`timescale 1ns/1ps

module crossbar (
        switch_req_if.xbar_side         req_bus [noc_pkg::NUM_PORTS],
        input  logic                    out_free [noc_pkg::NUM_PORTS],
        output noc_pkg::flit_t          out_flit [noc_pkg::NUM_PORTS],
        output logic                    out_valid [noc_pkg::NUM_PORTS]
);

        localparam int N = noc_pkg::NUM_PORTS;

        logic [N-1:0]           req_v;
        logic [N-1:0]           pop_v;
        logic [N-1:0]           grant_v [N];
        noc_pkg::flit_t         head_v [N];

        for (genvar i = 0; i < N; i++) begin : g_port
                assign req_v[i]       = req_bus[i].req;
                assign grant_v[i]     = req_bus[i].grant;
                assign head_v[i]      = req_bus[i].head_flit;
                assign req_bus[i].pop = pop_v[i];
        end

        // grants are gated by the output register being able to take a flit
        always_comb begin
                pop_v = '0;
                for (int o = 0; o < N; o++) begin
                        out_flit[o]  = '0;
                        out_valid[o] = 1'b0;
                        for (int i = 0; i < N; i++) begin
                                if (grant_v[i][o]) begin
                                        out_flit[o]  = head_v[i];
                                        out_valid[o] = req_v[i] && out_free[o];
                                        pop_v[i]     = pop_v[i] | (req_v[i] && out_free[o]);
                                end
                        end
                end
        end

endmodule

//--- design/input_port.sv
`timescale 1ns/1ps

module input_port #(
        parameter int FIFO_DEPTH = 4
) (
        input  logic                            clk,
        input  logic                            rst_n,
        input  noc_pkg::flit_t                  idata,
        input  logic                            ivalid,
        input  logic [noc_pkg::POS_W-1:0]       my_xpos,
        input  logic [noc_pkg::POS_W-1:0]       my_ypos,
        output logic                            ordy,
        switch_req_if.port_side                 req_bus
);

        localparam int PTR_W = $clog2(FIFO_DEPTH);
        localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

        noc_pkg::flit_t                 mem [FIFO_DEPTH];
        logic [PTR_W-1:0]               wr_ptr;
        logic [PTR_W-1:0]               rd_ptr;
        logic [CNT_W-1:0]               count;
        logic [CNT_W-1:0]               count_next;
        noc_pkg::flit_t                 head;
        logic                           head_is_hdr;
        logic [noc_pkg::PORT_W-1:0]     route_now;
        logic [noc_pkg::PORT_W-1:0]     route_q;

        // dimension order, x resolved first
        function automatic logic [noc_pkg::PORT_W-1:0] xy_route(
                input logic [noc_pkg::POS_W-1:0] dst_x,
                input logic [noc_pkg::POS_W-1:0] dst_y,
                input logic [noc_pkg::POS_W-1:0] cur_x,
                input logic [noc_pkg::POS_W-1:0] cur_y
        );
                if (dst_x > cur_x)
                        return noc_pkg::PORT_EAST;
                if (dst_x < cur_x)
                        return noc_pkg::PORT_WEST;
                if (dst_y > cur_y)
                        return noc_pkg::PORT_NORTH;
                if (dst_y < cur_y)
                        return noc_pkg::PORT_SOUTH;
                return noc_pkg::PORT_LOCAL;
        endfunction

        assign head        = mem[rd_ptr];
        assign head_is_hdr = (head.kind == noc_pkg::HEAD) || (head.kind == noc_pkg::SINGLE);
        assign route_now   = xy_route(head.payload[1:0], head.payload[3:2], my_xpos, my_ypos);
        assign count_next  = count + CNT_W'(ivalid) - CNT_W'(req_bus.pop);

        assign req_bus.req       = (count != '0);
        assign req_bus.head_flit = head;
        assign req_bus.dest      = head_is_hdr ? route_now : route_q;
        assign req_bus.last      = (head.kind == noc_pkg::TAIL) || (head.kind == noc_pkg::SINGLE);

        always_ff @(posedge clk) begin
                if (ivalid)
                        mem[wr_ptr] <= idata;
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                        ordy   <= 1'b1;
                end else begin
                        if (ivalid)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (req_bus.pop)
                                rd_ptr <= rd_ptr + 1'b1;
                        count <= count_next;
                        ordy  <= (count_next != CNT_W'(FIFO_DEPTH));
                end
        end

        // body flits follow the route of their head
        always_ff @(posedge clk) begin
                if (!rst_n)
                        route_q <= noc_pkg::PORT_LOCAL;
                else if (req_bus.req && head_is_hdr)
                        route_q <= route_now;
        end

        // upstream honours ordy
        a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
                ivalid |-> (count != CNT_W'(FIFO_DEPTH)));

        // crossbar only takes a flit that is there
        a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
                req_bus.pop |-> (count != '0));

endmodule

//--- design/noc_pkg.sv
package noc_pkg;

        localparam int NUM_PORTS = 5;
        localparam int PORT_W    = 3;
        localparam int POS_W     = 2;
        localparam int PAYLOAD_W = 32;

        // port numbering, north is +y and east is +x
        localparam logic [PORT_W-1:0] PORT_LOCAL = 3'd0;
        localparam logic [PORT_W-1:0] PORT_NORTH = 3'd1;
        localparam logic [PORT_W-1:0] PORT_EAST  = 3'd2;
        localparam logic [PORT_W-1:0] PORT_SOUTH = 3'd3;
        localparam logic [PORT_W-1:0] PORT_WEST  = 3'd4;

        // single is a one-flit packet, head and tail at once
        typedef enum logic [1:0] {
                HEAD   = 2'd0,
                BODY   = 2'd1,
                TAIL   = 2'd2,
                SINGLE = 2'd3
        } flit_kind_t;

        // head and single flits carry dest x in payload[1:0], dest y in payload[3:2]
        typedef struct packed {
                flit_kind_t             kind;
                logic [PAYLOAD_W-1:0]   payload;
        } flit_t;

endpackage

//--- design/output_port.sv
`timescale 1ns/1ps

module output_port (
        input  logic                    clk,
        input  logic                    rst_n,
        input  noc_pkg::flit_t          in_flit,
        input  logic                    in_valid,
        input  logic                    iack,
        output logic                    free,
        output noc_pkg::flit_t          odata,
        output logic                    ovalid
);

        logic                   full;
        noc_pkg::flit_t         data_q;

        // a flit being acked this cycle can be replaced at the same edge
        assign free   = !full || iack;
        assign odata  = data_q;
        assign ovalid = full;

        always_ff @(posedge clk) begin
                if (in_valid)
                        data_q <= in_flit;
        end

        always_ff @(posedge clk) begin
                if (!rst_n)
                        full <= 1'b0;
                else if (in_valid)
                        full <= 1'b1;
                else if (iack)
                        full <= 1'b0;
        end

        // hold until the downstream router takes it
        a_hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
                (ovalid && !iack) |=> (ovalid && $stable(odata)));

endmodule

//--- design/router.sv
`timescale 1ns/1ps

module router #(
        parameter int FIFO_DEPTH = 4
) (
        input  logic                            clk,
        input  logic                            rst_n,
        input  noc_pkg::flit_t                  idata [noc_pkg::NUM_PORTS],
        input  logic                            ivalid [noc_pkg::NUM_PORTS],
        output logic                            ordy [noc_pkg::NUM_PORTS],
        output noc_pkg::flit_t                  odata [noc_pkg::NUM_PORTS],
        output logic                            ovalid [noc_pkg::NUM_PORTS],
        input  logic                            iack [noc_pkg::NUM_PORTS],
        input  logic [noc_pkg::POS_W-1:0]       my_xpos,
        input  logic [noc_pkg::POS_W-1:0]       my_ypos
);

        localparam int N = noc_pkg::NUM_PORTS;

        // one request bus per input port
        switch_req_if req_bus [N] ();

        noc_pkg::flit_t         xb_flit [N];
        logic                   xb_valid [N];
        logic                   op_free [N];

        for (genvar p = 0; p < N; p++) begin : g_in
                input_port #(
                        .FIFO_DEPTH     (FIFO_DEPTH)
                ) ip (
                        .clk            (clk),
                        .rst_n          (rst_n),
                        .idata          (idata[p]),
                        .ivalid         (ivalid[p]),
                        .my_xpos        (my_xpos),
                        .my_ypos        (my_ypos),
                        .ordy           (ordy[p]),
                        .req_bus        (req_bus[p])
                );
        end

        switch_alloc sa (
                .clk            (clk),
                .rst_n          (rst_n),
                .req_bus        (req_bus)
        );

        crossbar xb (
                .req_bus        (req_bus),
                .out_free       (op_free),
                .out_flit       (xb_flit),
                .out_valid      (xb_valid)
        );

        for (genvar p = 0; p < N; p++) begin : g_out
                output_port op (
                        .clk            (clk),
                        .rst_n          (rst_n),
                        .in_flit        (xb_flit[p]),
                        .in_valid       (xb_valid[p]),
                        .iack           (iack[p]),
                        .free           (op_free[p]),
                        .odata          (odata[p]),
                        .ovalid         (ovalid[p])
                );
        end

endmodule

//--- design/switch_alloc.sv
`timescale 1ns/1ps

module switch_alloc (
        input  logic                    clk,
        input  logic                    rst_n,
        switch_req_if.alloc_side        req_bus [noc_pkg::NUM_PORTS]
);

        localparam int N = noc_pkg::NUM_PORTS;
        localparam int W = noc_pkg::PORT_W;

        logic [N-1:0]   req_v;
        logic [N-1:0]   pop_v;
        logic [N-1:0]   last_v;
        logic [W-1:0]   dest_v [N];
        logic [N-1:0]   grant_row [N];

        // per output state, owner kept one-hot over inputs
        logic [N-1:0]   busy;
        logic [N-1:0]   owner_oh [N];
        logic [W-1:0]   rr_ptr [N];
        logic [N-1:0]   win_any;
        logic [W-1:0]   win_idx [N];

        for (genvar i = 0; i < N; i++) begin : g_port
                assign req_v[i]         = req_bus[i].req;
                assign pop_v[i]         = req_bus[i].pop;
                assign last_v[i]        = req_bus[i].last;
                assign dest_v[i]        = req_bus[i].dest;
                assign req_bus[i].grant = grant_row[i];
        end

        always_comb begin
                for (int i = 0; i < N; i++) begin
                        for (int o = 0; o < N; o++)
                                grant_row[i][o] = owner_oh[o][i];
                end
        end

        // round robin search, starting after the last winner
        always_comb begin
                int cand;
                for (int o = 0; o < N; o++) begin
                        win_any[o] = 1'b0;
                        win_idx[o] = '0;
                        for (int k = 1; k <= N; k++) begin
                                cand = (int'(rr_ptr[o]) + k) % N;
                                if (!win_any[o] && req_v[cand] && dest_v[cand] == W'(o)) begin
                                        win_any[o] = 1'b1;
                                        win_idx[o] = W'(cand);
                                end
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        busy <= '0;
                        for (int o = 0; o < N; o++) begin
                                owner_oh[o] <= '0;
                                rr_ptr[o]   <= W'(N - 1);
                        end
                end else begin
                        for (int o = 0; o < N; o++) begin
                                if (busy[o]) begin
                                        // released when the owner's tail leaves
                                        if (|(owner_oh[o] & pop_v & last_v)) begin
                                                busy[o]     <= 1'b0;
                                                owner_oh[o] <= '0;
                                        end
                                end else if (win_any[o]) begin
                                        busy[o]     <= 1'b1;
                                        owner_oh[o] <= N'(1) << win_idx[o];
                                        rr_ptr[o]   <= win_idx[o];
                                end
                        end
                end
        end

        for (genvar g = 0; g < N; g++) begin : g_chk
                a_col_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                        $onehot0(owner_oh[g]) && (busy[g] == (owner_oh[g] != '0)));
                // an input never holds two outputs at once
                a_row_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                        $onehot0(grant_row[g]));
        end

endmodule

//--- design/switch_req_if.sv
`timescale 1ns/1ps

interface switch_req_if;

        logic                           req;
        logic [noc_pkg::PORT_W-1:0]     dest;
        noc_pkg::flit_t                 head_flit;
        logic                           last;
        logic [noc_pkg::NUM_PORTS-1:0]  grant;
        logic                           pop;

        modport port_side (
                output req, dest, head_flit, last,
                input  pop
        );

        modport alloc_side (
                input  req, dest, last, pop,
                output grant
        );

        modport xbar_side (
                input  req, head_flit, grant,
                output pop
        );

endinterface

//--- sim/router_tb.sv
`timescale 1ns/1ps

module router_tb;

        localparam int N            = noc_pkg::NUM_PORTS;
        localparam int MY_X         = 1;
        localparam int MY_Y         = 2;
        localparam int PKTS_PER_SRC = 16;
        localparam int SEND_LIMIT   = 5000;
        localparam int DRAIN_LIMIT  = 500;

        logic                   clk = 1'b0;
        logic                   rst_n;
        noc_pkg::flit_t         idata [N];
        logic                   ivalid [N];
        logic                   ordy [N];
        noc_pkg::flit_t         odata [N];
        logic                   ovalid [N];
        logic                   iack [N];

        logic [15:0]            lfsr;
        logic                   run;
        int                     bp_mode;
        int                     err_cnt;
        int                     sent_cnt;
        int                     recv_cnt;
        logic                   saw_ordy_low;

        // per source packet state
        int                     pkt_left [N];
        int                     pkts_done [N];
        int                     cur_out [N];
        int                     seq [N];
        logic                   sent_last [N];

        // expected flits, indexed src*N + out
        noc_pkg::flit_t         exp_q [N*N][$];
        int                     open_src [N];
        logic                   prev_valid [N];
        logic                   prev_ack [N];
        noc_pkg::flit_t         prev_data [N];

        router #(
                .FIFO_DEPTH     (4)
        ) dut0 (
                .clk            (clk),
                .rst_n          (rst_n),
                .idata          (idata),
                .ivalid         (ivalid),
                .ordy           (ordy),
                .odata          (odata),
                .ovalid         (ovalid),
                .iack           (iack),
                .my_xpos        (2'(MY_X)),
                .my_ypos        (2'(MY_Y))
        );

        always #2 clk = ~clk;

        // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
        function automatic int take_bits(input int n);
                int r;
                logic fb;
                r = 0;
                for (int i = 0; i < n; i++) begin
                        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
                        lfsr = {lfsr[14:0], fb};
                        r    = (r << 1) | int'(fb);
                end
                return r;
        endfunction

        // x first, then y
        function automatic int xy_ref(input int dx, input int dy);
                if (dx != MY_X)
                        return (dx > MY_X) ? noc_pkg::PORT_EAST : noc_pkg::PORT_WEST;
                if (dy != MY_Y)
                        return (dy > MY_Y) ? noc_pkg::PORT_NORTH : noc_pkg::PORT_SOUTH;
                return noc_pkg::PORT_LOCAL;
        endfunction

        // seq in [31:16], source in [7:5], destination in [3:0]
        function automatic logic [noc_pkg::PAYLOAD_W-1:0] make_payload(
                input int src,
                input int sq,
                input int dx,
                input int dy
        );
                return {16'(sq), 8'h00, 3'(src), 1'b0, 2'(dy), 2'(dx)};
        endfunction

        function automatic logic src_done(input int p);
                return (pkt_left[p] == 0) && (pkts_done[p] == PKTS_PER_SRC);
        endfunction

        function automatic logic all_sent();
                logic done;
                done = 1'b1;
                for (int p = 0; p < N; p++)
                        done = done & src_done(p);
                return done;
        endfunction

        function automatic int pending_flits();
                int total;
                total = 0;
                for (int i = 0; i < N*N; i++)
                        total += exp_q[i].size();
                return total;
        endfunction

        // a flit not taken last cycle must still be there unchanged
        task automatic check_hold(input int o);
                if (prev_valid[o] && !prev_ack[o]) begin
                        assert (ovalid[o]) else begin
                                err_cnt++;
                                $display("** Error at %0t: ovalid[%0d] = %b, expected 1",
                                         $time, o, ovalid[o]);
                        end
                        assert (odata[o] == prev_data[o]) else begin
                                err_cnt++;
                                $display("** Error at %0t: odata[%0d] = %h, expected held %h",
                                         $time, o, odata[o], prev_data[o]);
                        end
                end
                prev_valid[o] = ovalid[o];
                prev_ack[o]   = iack[o];
                prev_data[o]  = odata[o];
        endtask

        // one flit taken by the downstream side of output o
        task automatic check_accepted(input int o);
                noc_pkg::flit_t f;
                noc_pkg::flit_t exp_f;
                int src;
                int qi;
                int want;
                f   = odata[o];
                src = int'(f.payload[7:5]);
                qi  = src * N + o;
                if (f.kind == noc_pkg::HEAD || f.kind == noc_pkg::SINGLE) begin
                        want = xy_ref(int'(f.payload[1:0]), int'(f.payload[3:2]));
                        assert (o == want) else begin
                                err_cnt++;
                                $display("** Error at %0t: head on odata[%0d], expected port %0d",
                                         $time, o, want);
                        end
                        assert (open_src[o] < 0) else begin
                                err_cnt++;
                                $display("output %0d started a packet inside another one", o);
                        end
                        open_src[o] = (f.kind == noc_pkg::HEAD) ? src : -1;
                end else begin
                        assert (open_src[o] == src) else begin
                                err_cnt++;
                                $display("output %0d: flit of source %0d outside its packet",
                                         o, src);
                        end
                        if (f.kind == noc_pkg::TAIL)
                                open_src[o] = -1;
                end
                assert (src < N && exp_q[qi].size() != 0) else begin
                        err_cnt++;
                        $display("output %0d delivered a flit that was not expected: %h", o, f);
                end
                if (src < N && exp_q[qi].size() != 0) begin
                        exp_f = exp_q[qi].pop_front();
                        assert (f == exp_f) else begin
                                err_cnt++;
                                $display("** Error at %0t: odata[%0d] = %h, expected %h",
                                         $time, o, f, exp_f);
                        end
                end
        endtask

        // sources and iack
        always @(posedge clk) begin : drive
                int dx;
                int dy;
                int len;
                int out;
                int nsent;
                logic can_send;
                noc_pkg::flit_t f;
                nsent = 0;
                if (run) begin
                        for (int p = 0; p < N; p++) begin
                                ivalid[p]    <= 1'b0;
                                sent_last[p] <= 1'b0;
                                // a flit sent last cycle is not yet reflected in ordy
                                can_send = !sent_last[p] && ordy[p] && !src_done(p);
                                if (can_send && take_bits(1) == 1) begin
                                        if (pkt_left[p] == 0) begin
                                                if (pkts_done[p] == 0) begin
                                                        dx = MY_X;
                                                        dy = MY_Y;
                                                end else begin
                                                        dx = take_bits(2);
                                                        dy = take_bits(2);
                                                end
                                                len       = take_bits(2) % 3 + 1;
                                                out       = xy_ref(dx, dy);
                                                f.kind    = (len == 1) ?
                                                            noc_pkg::SINGLE : noc_pkg::HEAD;
                                                f.payload = make_payload(p, seq[p], dx, dy);
                                                cur_out[p]  <= out;
                                                pkt_left[p] <= len - 1;
                                                if (len == 1)
                                                        pkts_done[p] <= pkts_done[p] + 1;
                                        end else begin
                                                out       = cur_out[p];
                                                f.kind    = (pkt_left[p] == 1) ?
                                                            noc_pkg::TAIL : noc_pkg::BODY;
                                                f.payload = make_payload(p, seq[p], 0, 0);
                                                pkt_left[p] <= pkt_left[p] - 1;
                                                if (pkt_left[p] == 1)
                                                        pkts_done[p] <= pkts_done[p] + 1;
                                        end
                                        exp_q[p*N + out].push_back(f);
                                        idata[p]     <= f;
                                        ivalid[p]    <= 1'b1;
                                        sent_last[p] <= 1'b1;
                                        seq[p]       <= seq[p] + 1;
                                        nsent++;
                                end
                        end
                        for (int o = 0; o < N; o++) begin
                                case (bp_mode)
                                        0:       iack[o] <= (take_bits(2) != 0);
                                        1:       iack[o] <= 1'b0;
                                        default: iack[o] <= 1'b1;
                                endcase
                        end
                        sent_cnt <= sent_cnt + nsent;
                end
        end

        always @(posedge clk) begin : compare
                int got;
                got = 0;
                if (run) begin
                        for (int p = 0; p < N; p++) begin
                                if (!ordy[p])
                                        saw_ordy_low = 1'b1;
                                assert (!ivalid[p] || ordy[p]) else begin
                                        err_cnt++;
                                        $display("ivalid[%0d] driven while ordy low at %0t",
                                                 p, $time);
                                end
                        end
                        for (int o = 0; o < N; o++) begin
                                check_hold(o);
                                if (ovalid[o] && iack[o]) begin
                                        check_accepted(o);
                                        got++;
                                end
                        end
                        recv_cnt <= recv_cnt + got;
                end
        end

        initial begin : main
                int waited;
                logic timed_out;
                lfsr         = 16'd68;
                rst_n        = 1'b0;
                run          = 1'b0;
                bp_mode      = 0;
                err_cnt      = 0;
                sent_cnt     = 0;
                recv_cnt     = 0;
                saw_ordy_low = 1'b0;
                timed_out    = 1'b0;
                for (int p = 0; p < N; p++) begin
                        idata[p]      = '0;
                        ivalid[p]     = 1'b0;
                        iack[p]       = 1'b0;
                        pkt_left[p]   = 0;
                        pkts_done[p]  = 0;
                        cur_out[p]    = 0;
                        seq[p]        = 0;
                        sent_last[p]  = 1'b0;
                        open_src[p]   = -1;
                        prev_valid[p] = 1'b0;
                        prev_ack[p]   = 1'b0;
                        prev_data[p]  = '0;
                end
                repeat (3) @(posedge clk);
                rst_n <= 1'b1;
                @(posedge clk);
                for (int p = 0; p < N; p++) begin
                        assert (!ovalid[p]) else begin
                                err_cnt++;
                                $display("** Error at %0t: ovalid[%0d] = %b, expected 0",
                                         $time, p, ovalid[p]);
                        end
                        assert (ordy[p]) else begin
                                err_cnt++;
                                $display("** Error at %0t: ordy[%0d] = %b, expected 1",
                                         $time, p, ordy[p]);
                        end
                end
                run <= 1'b1;
                repeat (40) @(posedge clk);
                // stall every output so buffers fill
                bp_mode <= 1;
                repeat (40) @(posedge clk);
                bp_mode <= 0;
                waited = 0;
                while (!all_sent() && !timed_out) begin
                        @(posedge clk);
                        waited++;
                        if (waited > SEND_LIMIT) begin
                                timed_out = 1'b1;
                                $display("timed out waiting for the sources to finish");
                        end
                end
                if (!timed_out) begin
                        bp_mode <= 2;
                        waited = 0;
                        while (recv_cnt != sent_cnt && !timed_out) begin
                                @(posedge clk);
                                waited++;
                                if (waited > DRAIN_LIMIT) begin
                                        timed_out = 1'b1;
                                        $display("timed out waiting for the outputs to drain");
                                end
                        end
                end
                if (!timed_out) begin
                        repeat (3) @(posedge clk);
                        assert (pending_flits() == 0) else begin
                                err_cnt++;
                                $display("%0d expected flits never arrived", pending_flits());
                        end
                        assert (saw_ordy_low) else begin
                                err_cnt++;
                                $display("ordy never dropped under back-pressure");
                        end
                        for (int o = 0; o < N; o++) begin
                                assert (!ovalid[o] && open_src[o] < 0) else begin
                                        err_cnt++;
                                        $display("output %0d did not end idle", o);
                                end
                        end
                end
                $display("router_tb: %0d flits sent, %0d received, %0d errors, %0d timeouts",
                         sent_cnt, recv_cnt, err_cnt, int'(timed_out));
                if (err_cnt == 0 && !timed_out)
                        $display("** PASS **");
                else
                        $display("** FAIL **");
                $finish;
        end

endmodule

//--- sources.f
design/noc_pkg.sv
design/switch_req_if.sv
design/input_port.sv
design/switch_alloc.sv
design/crossbar.sv
design/output_port.sv
design/router.sv
sim/router_tb.sv
